/* tb.f */
src/fetch_pkg.sv
src/icache_pkg.sv
src/fetch_ctrl.sv
src/fetch_addr_gen.sv
src/itlb.sv
src/icache_bank.sv
src/fetch_top.sv
bench/tb_clkgen.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front

sources:
  - src/fetch_pkg.sv
  - src/icache_pkg.sv
  - src/fetch_ctrl.sv
  - src/fetch_addr_gen.sv
  - src/itlb.sv
  - src/icache_bank.sv
  - src/fetch_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/fetch_tb.sv

/* bench/fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb;

    logic                                   clk_i, arst_n_i;
    logic                                   init_i, resteer_i, br_taken_i;
    logic                                   even_taken_i, odd_taken_i;
    logic [fetch_pkg::VADDR_W-1:0]          init_addr_i;
    logic [fetch_pkg::LADDR_W-1:0]          wb_fip_e_i, wb_fip_o_i, bp_fip_e_i, bp_fip_o_i;
    logic [icache_pkg::TLB_ENTRIES*icache_pkg::VPN_W-1:0]  tlb_vp_i;
    logic [icache_pkg::TLB_ENTRIES*icache_pkg::PFN_W-1:0]  tlb_pf_i;
    logic [icache_pkg::TLB_ENTRIES-1:0]     tlb_valid_i, tlb_present_i;
    logic                                   fill_valid_e_i, fill_valid_o_i;
    logic [icache_pkg::LINE_W-1:0]          fill_line_e_i, fill_line_o_i;
    logic [fetch_pkg::LADDR_W-1:0]          fetch_line_e_o, fetch_line_o_o;
    logic [icache_pkg::LINE_W-1:0]          line_e_o, line_o_o;
    logic                                   hit_e_o, hit_o_o, miss_e_o, miss_o_o;
    logic [icache_pkg::PADDR_W-1:0]         miss_paddr_e_o, miss_paddr_o_o;
    logic                                   tlb_miss_e_o, tlb_miss_o_o;

    // reference tlb table and expected state
    logic [19:0]    tb_vp [8];
    logic [2:0]     tb_pf [8];
    logic [7:0]     tb_valid, tb_present;
    logic [27:0]    exp_e, exp_o;                // expected fetch line registers
    logic [127:0]   filled [logic [10:0]];      // lines written by physical line address
    string          test_name;

    tb_clkgen clkgen0 (.clk_o(clk_i), .arst_n_o(arst_n_i));

    fetch_top dut0 (.*);

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string sig, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("error %s %s: expected %0h, actual %0h", test_name, sig, exp, act);
            stop_run();
        end
    endtask

    // {miss, pfn} from the first valid and present entry counting up
    function automatic logic [3:0] translate(input logic [27:0] fl);
        logic [3:0] res;
        logic       found;
        res = 4'b1000;
        found = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (!found && tb_valid[i] && tb_present[i] && tb_vp[i] == fl[27:8]) begin
                res = {1'b0, tb_pf[i]};
                found = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic bit bank_ready(input bit odd);
        logic [27:0] fl;
        logic [3:0]  tr;
        fl = odd ? exp_o : exp_e;
        tr = translate(fl);
        return !tr[3] && filled.exists({tr[2:0], fl[7:0]});
    endfunction

    task automatic check_lines();
        check("fetch_line_e", exp_e, fetch_line_e_o);
        check("fetch_line_o", exp_o, fetch_line_o_o);
    endtask

    task automatic check_lookup(input bit odd);
        logic [27:0]  fl;
        logic [3:0]   tr;
        logic [10:0]  key;
        logic         present;
        string        bank;
        fl = odd ? exp_o : exp_e;
        tr = translate(fl);
        key = {tr[2:0], fl[7:0]};
        present = filled.exists(key);
        bank = odd ? "odd" : "even";
        check({bank, " tlb_miss"}, tr[3], odd ? tlb_miss_o_o : tlb_miss_e_o);
        check({bank, " hit"}, !tr[3] && present, odd ? hit_o_o : hit_e_o);
        check({bank, " miss"}, !tr[3] && !present, odd ? miss_o_o : miss_e_o);
        if (!tr[3]) begin
            check({bank, " miss_paddr"}, {key, 4'h0}, odd ? miss_paddr_o_o : miss_paddr_e_o);
        end
        if (!tr[3] && present) begin
            check({bank, " line"}, filled[key], odd ? line_o_o : line_e_o);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic logic [159:0] pack_vp();
        logic [159:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*20 +: 20] = tb_vp[i];
        end
        return v;
    endfunction

    function automatic logic [23:0] pack_pf();
        logic [23:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*3 +: 3] = tb_pf[i];
        end
        return v;
    endfunction

    task automatic load_tlb();
        @(posedge clk_i);
        tlb_vp_i      <= pack_vp();
        tlb_pf_i      <= pack_pf();
        tlb_valid_i   <= tb_valid;
        tlb_present_i <= tb_present;
        @(negedge clk_i);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (arst_n_i !== 1'b1 && n < 40) begin
            @(negedge clk_i);
            n++;
        end
        if (arst_n_i !== 1'b1) begin
            $display("timeout: reset was never released");
            stop_run();
        end
    endtask

    // req bits are init, resteer and branch
    task automatic redirect(input logic [2:0] req, input logic [31:0] ia,
                            input logic [27:0] we, input logic [27:0] wo,
                            input logic [27:0] be, input logic [27:0] bo);
        if (req[2]) begin
            exp_e = ia[4] ? ia[31:4] + 28'd1 : ia[31:4];
            exp_o = ia[4] ? ia[31:4] : ia[31:4] + 28'd1;
        end else if (req[1]) begin
            exp_e = we;
            exp_o = wo;
        end else begin
            exp_e = be;
            exp_o = bo;
        end
        @(posedge clk_i);
        init_i      <= req[2];
        resteer_i   <= req[1];
        br_taken_i  <= req[0];
        init_addr_i <= ia;
        wb_fip_e_i  <= we;
        wb_fip_o_i  <= wo;
        bp_fip_e_i  <= be;
        bp_fip_o_i  <= bo;
        @(negedge clk_i);
        check_lines();      // same cycle
        @(posedge clk_i);
        init_i     <= 1'b0;
        resteer_i  <= 1'b0;
        br_taken_i <= 1'b0;
        @(negedge clk_i);
        exp_e = exp_e + 28'd2;
        exp_o = exp_o + 28'd2;
        check_lines();
    endtask

    // one-cycle taken strobes where a stalled bank holds
    task automatic pulse_taken(input bit ev, input bit od);
        bit rdy_e, rdy_o;
        rdy_e = bank_ready(1'b0);
        rdy_o = bank_ready(1'b1);
        @(posedge clk_i);
        even_taken_i <= ev;
        odd_taken_i  <= od;
        @(posedge clk_i);
        even_taken_i <= 1'b0;
        odd_taken_i  <= 1'b0;
        @(negedge clk_i);
        if (ev && rdy_e) exp_e = exp_e + 28'd2;
        if (od && rdy_o) exp_o = exp_o + 28'd2;
        check_lines();
        check_lookup(1'b0);
        check_lookup(1'b1);
    endtask

    task automatic fill_bank(input bit odd);
        logic [127:0] data;
        logic [27:0]  fl;
        logic [3:0]   tr;
        int           n;
        data = {$urandom, $urandom, $urandom, $urandom};
        fl = odd ? exp_o : exp_e;
        tr = translate(fl);
        @(posedge clk_i);
        if (odd) begin
            fill_valid_o_i <= 1'b1;
            fill_line_o_i  <= data;
        end else begin
            fill_valid_e_i <= 1'b1;
            fill_line_e_i  <= data;
        end
        @(posedge clk_i);
        fill_valid_e_i <= 1'b0;
        fill_valid_o_i <= 1'b0;
        filled[{tr[2:0], fl[7:0]}] = data;
        n = 1;
        @(negedge clk_i);
        while (!(odd ? hit_o_o : hit_e_o) && n < 8) begin
            @(negedge clk_i);
            n++;
        end
        if (!(odd ? hit_o_o : hit_e_o)) begin
            $display("timeout: no hit after a fill in test %s", test_name);
            stop_run();
        end
        check("hit latency", 1, n);
        check_lines();      // held through the miss
        check_lookup(odd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        test_name = "reset_state";
        exp_e = 28'd0;
        exp_o = 28'd1;
        @(negedge clk_i);
        check_lines();
        check_lookup(1'b0);
        check_lookup(1'b1);
    endtask

    task automatic test_init_split();
        logic [31:0] a;
        test_name = "init_split";
        a = $urandom;
        redirect(3'b100, {a[31:5], 1'b0, a[3:0]}, '0, '0, '0, '0);
        a = $urandom;
        redirect(3'b100, {a[31:5], 1'b1, a[3:0]}, '0, '0, '0, '0);
    endtask

    task automatic test_priority();
        logic [2:0] req;
        test_name = "priority";
        for (int i = 0; i < 12; i++) begin
            req = $urandom_range(7, 1);
            redirect(req, $urandom, $urandom, $urandom, $urandom, $urandom);
        end
    endtask

    task automatic test_miss_fill();
        test_name = "miss_fill_hit";
        redirect(3'b100, 32'h0000_5340, '0, '0, '0, '0);   // page 5
        check_lookup(1'b0);
        check_lookup(1'b1);
        pulse_taken(1'b1, 1'b1);    // both missing so no advance
        fill_bank(1'b0);
        fill_bank(1'b1);
    endtask

    task automatic test_advance();
        test_name = "sequential_advance";
        for (int r = 0; r < 3; r++) begin
            pulse_taken(1'b1, 1'b0);
            fill_bank(1'b0);
            pulse_taken(1'b0, 1'b1);
            fill_bank(1'b1);
        end
        pulse_taken(1'b1, 1'b1);
    endtask

    task automatic test_tlb_miss();
        test_name = "tlb_miss";
        tb_valid[exp_e[10:8]] = 1'b0;
        load_tlb();
        check_lookup(1'b0);
        check_lookup(1'b1);
        pulse_taken(1'b1, 1'b1);
        tb_valid = '1;
        load_tlb();
        check_lines();
        check_lookup(1'b0);
        check_lookup(1'b1);
    endtask

    initial begin
        int unsigned seed;
        seed = 32'h9be857ab;
        void'($urandom(seed));
        init_i = 1'b0;
        resteer_i = 1'b0;
        br_taken_i = 1'b0;
        even_taken_i = 1'b0;
        odd_taken_i = 1'b0;
        init_addr_i = '0;
        wb_fip_e_i = '0;
        wb_fip_o_i = '0;
        bp_fip_e_i = '0;
        bp_fip_o_i = '0;
        fill_valid_e_i = 1'b0;
        fill_valid_o_i = 1'b0;
        fill_line_e_i = '0;
        fill_line_o_i = '0;
        // identity table mapping page i to frame i
        for (int i = 0; i < 8; i++) begin
            tb_vp[i] = i;
            tb_pf[i] = i;
        end
        tb_valid = '1;
        tb_present = '1;
        tlb_vp_i = pack_vp();
        tlb_pf_i = pack_pf();
        tlb_valid_i = tb_valid;
        tlb_present_i = tb_present;
        wait_reset();
        test_reset();
        test_init_split();
        test_priority();
        test_miss_fill();
        test_advance();
        test_tlb_miss();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* bench/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk_o,
    output logic arst_n_o
);

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o;
        end
    end

    // reset held for 16 rising edges, released on an edge
    initial begin
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* src/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
    input  logic                                                  clk_i,
    input  logic                                                  arst_n_i,
    input  logic                                                  init_i,
    input  logic [fetch_pkg::VADDR_W-1:0]                         init_addr_i,
    input  logic                                                  resteer_i,
    input  logic [fetch_pkg::LADDR_W-1:0]                         wb_fip_e_i,
    input  logic [fetch_pkg::LADDR_W-1:0]                         wb_fip_o_i,
    input  logic                                                  br_taken_i,
    input  logic [fetch_pkg::LADDR_W-1:0]                         bp_fip_e_i,
    input  logic [fetch_pkg::LADDR_W-1:0]                         bp_fip_o_i,
    input  logic                                                  even_taken_i,
    input  logic                                                  odd_taken_i,
    input  logic [icache_pkg::TLB_ENTRIES*icache_pkg::VPN_W-1:0]  tlb_vp_i,
    input  logic [icache_pkg::TLB_ENTRIES*icache_pkg::PFN_W-1:0]  tlb_pf_i,
    input  logic [icache_pkg::TLB_ENTRIES-1:0]                    tlb_valid_i,
    input  logic [icache_pkg::TLB_ENTRIES-1:0]                    tlb_present_i,
    input  logic                                                  fill_valid_e_i,
    input  logic [icache_pkg::LINE_W-1:0]                         fill_line_e_i,
    input  logic                                                  fill_valid_o_i,
    input  logic [icache_pkg::LINE_W-1:0]                         fill_line_o_i,
    output logic [fetch_pkg::LADDR_W-1:0]                         fetch_line_e_o,
    output logic [fetch_pkg::LADDR_W-1:0]                         fetch_line_o_o,
    output logic [icache_pkg::LINE_W-1:0]                         line_e_o,
    output logic [icache_pkg::LINE_W-1:0]                         line_o_o,
    output logic                                                  hit_e_o,
    output logic                                                  hit_o_o,
    output logic                                                  miss_e_o,
    output logic                                                  miss_o_o,
    output logic [icache_pkg::PADDR_W-1:0]                        miss_paddr_e_o,
    output logic [icache_pkg::PADDR_W-1:0]                        miss_paddr_o_o,
    output logic                                                  tlb_miss_e_o,
    output logic                                                  tlb_miss_o_o
);

    logic [fetch_pkg::CF_SEL_W-1:0]     cf_sel;
    logic                               is_cf;
    logic                               ld_e, ld_o;
    logic [fetch_pkg::LADDR_W-1:0]      init_line_e, init_line_o;
    logic [icache_pkg::PFN_W-1:0]       pfn_even, pfn_odd;
    logic                               stall_even, stall_odd;  // back to the controller

    fetch_ctrl u_ctrl (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .init_i(init_i), .init_addr_i(init_addr_i),
        .resteer_i(resteer_i), .br_taken_i(br_taken_i),
        .even_taken_i(even_taken_i), .odd_taken_i(odd_taken_i),
        .stall_e_i(stall_even), .stall_o_i(stall_odd),
        .cf_sel_o(cf_sel), .is_cf_o(is_cf), .ld_e_o(ld_e), .ld_o_o(ld_o),
        .init_line_e_o(init_line_e), .init_line_o_o(init_line_o)
    );

    //////////////////////////////////////////////////////////////////////
    // even bank
    //////////////////////////////////////////////////////////////////////

    fetch_addr_gen #(.PARITY(1'b0)) u_gen_e (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .init_line_i(init_line_e), .wb_line_i(wb_fip_e_i), .bp_line_i(bp_fip_e_i),
        .cf_sel_i(cf_sel), .is_cf_i(is_cf), .ld_i(ld_e),
        .fetch_line_o(fetch_line_e_o)
    );

    itlb u_tlb_e (
        .fetch_line_i(fetch_line_e_o),
        .tlb_vp_i(tlb_vp_i), .tlb_pf_i(tlb_pf_i),
        .tlb_valid_i(tlb_valid_i), .tlb_present_i(tlb_present_i),
        .pfn_o(pfn_even), .tlb_miss_o(tlb_miss_e_o)
    );

    icache_bank u_bank_e (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .fetch_line_i(fetch_line_e_o), .pfn_i(pfn_even), .tlb_miss_i(tlb_miss_e_o),
        .fill_valid_i(fill_valid_e_i), .fill_line_i(fill_line_e_i),
        .line_o(line_e_o), .hit_o(hit_e_o), .miss_o(miss_e_o),
        .miss_paddr_o(miss_paddr_e_o), .stall_o(stall_even)
    );

    //////////////////////////////////////////////////////////////////////
    // odd bank
    //////////////////////////////////////////////////////////////////////

    fetch_addr_gen #(.PARITY(1'b1)) u_gen_o (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .init_line_i(init_line_o), .wb_line_i(wb_fip_o_i), .bp_line_i(bp_fip_o_i),
        .cf_sel_i(cf_sel), .is_cf_i(is_cf), .ld_i(ld_o),
        .fetch_line_o(fetch_line_o_o)
    );

    itlb u_tlb_o (
        .fetch_line_i(fetch_line_o_o),
        .tlb_vp_i(tlb_vp_i), .tlb_pf_i(tlb_pf_i),
        .tlb_valid_i(tlb_valid_i), .tlb_present_i(tlb_present_i),
        .pfn_o(pfn_odd), .tlb_miss_o(tlb_miss_o_o)
    );

    icache_bank u_bank_o (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .fetch_line_i(fetch_line_o_o), .pfn_i(pfn_odd), .tlb_miss_i(tlb_miss_o_o),
        .fill_valid_i(fill_valid_o_i), .fill_line_i(fill_line_o_i),
        .line_o(line_o_o), .hit_o(hit_o_o), .miss_o(miss_o_o),
        .miss_paddr_o(miss_paddr_o_o), .stall_o(stall_odd)
    );

endmodule

/* src/icache_bank.sv */
`timescale 1ns/100ps

module icache_bank (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [fetch_pkg::LADDR_W-1:0]     fetch_line_i,
    input  logic [icache_pkg::PFN_W-1:0]      pfn_i,
    input  logic                              tlb_miss_i,
    input  logic                              fill_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]     fill_line_i,
    output logic [icache_pkg::LINE_W-1:0]     line_o,
    output logic                              hit_o,
    output logic                              miss_o,
    output logic [icache_pkg::PADDR_W-1:0]    miss_paddr_o,
    output logic                              stall_o
);

    fetch_pkg::fetch_addr_u                 vaddr;
    logic [icache_pkg::PADDR_W-1:0]         paddr;
    logic [icache_pkg::INDEX_W-1:0]         idx;
    logic [icache_pkg::TAG_W-1:0]           tag;
    logic                                   tag_match;

    // arrays
    logic [icache_pkg::TAG_W-1:0]           tag_q  [icache_pkg::NUM_SETS];
    logic [icache_pkg::LINE_W-1:0]          data_q [icache_pkg::NUM_SETS];
    logic [icache_pkg::NUM_SETS-1:0]        valid_q;

    //////////////////////////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////////////////////////

    assign vaddr = {fetch_line_i, {icache_pkg::LINE_OFF_W{1'b0}}};
    assign paddr = {pfn_i, vaddr.page.offset};     // frame + page offset
    assign idx   = vaddr.line.index;               // index sits inside the page offset
    assign tag   = paddr[icache_pkg::PADDR_W-1 -: icache_pkg::TAG_W];

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    assign tag_match = valid_q[idx] && (tag_q[idx] == tag);

    assign line_o  = data_q[idx];
    assign hit_o   = tag_match & ~tlb_miss_i;
    assign miss_o  = ~tag_match & ~tlb_miss_i;  // only a translated address can miss
    assign stall_o = miss_o | tlb_miss_i;

    // refill request address, line aligned
    assign miss_paddr_o = {paddr[icache_pkg::PADDR_W-1:icache_pkg::LINE_OFF_W],
                           {icache_pkg::LINE_OFF_W{1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // refill write, set picked by the held fetch address
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= fill_line_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_valid_i) begin
            valid_q[idx] <= 1'b1;
        end
    end

endmodule

/* src/itlb.sv */
`timescale 1ns/100ps

module itlb (
    input  logic [fetch_pkg::LADDR_W-1:0]                         fetch_line_i,
    input  logic [icache_pkg::TLB_ENTRIES*icache_pkg::VPN_W-1:0]  tlb_vp_i,
    input  logic [icache_pkg::TLB_ENTRIES*icache_pkg::PFN_W-1:0]  tlb_pf_i,
    input  logic [icache_pkg::TLB_ENTRIES-1:0]                    tlb_valid_i,
    input  logic [icache_pkg::TLB_ENTRIES-1:0]                    tlb_present_i,
    output logic [icache_pkg::PFN_W-1:0]                          pfn_o,
    output logic                                                  tlb_miss_o
);

    fetch_pkg::fetch_addr_u                 vaddr;
    logic [icache_pkg::TLB_ENTRIES-1:0]     match;

    assign vaddr = {fetch_line_i, {icache_pkg::LINE_OFF_W{1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // fully associative compare
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < icache_pkg::TLB_ENTRIES; i++) begin
            match[i] = tlb_valid_i[i] && tlb_present_i[i] &&
                       (tlb_vp_i[i*icache_pkg::VPN_W +: icache_pkg::VPN_W] == vaddr.page.vpn);
        end
    end

    // walk down so the lowest matching entry is written last
    always_comb begin
        pfn_o = '0;
        for (int i = icache_pkg::TLB_ENTRIES-1; i >= 0; i--) begin
            if (match[i]) begin
                pfn_o = tlb_pf_i[i*icache_pkg::PFN_W +: icache_pkg::PFN_W];
            end
        end
    end

    assign tlb_miss_o = ~|match;  // no valid and present entry

endmodule

/* src/fetch_addr_gen.sv */
`timescale 1ns/100ps

module fetch_addr_gen #(
    parameter bit PARITY = 1'b0     // bank of this register as lsb at reset
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [fetch_pkg::LADDR_W-1:0]     init_line_i,
    input  logic [fetch_pkg::LADDR_W-1:0]     wb_line_i,
    input  logic [fetch_pkg::LADDR_W-1:0]     bp_line_i,
    input  logic [fetch_pkg::CF_SEL_W-1:0]    cf_sel_i,
    input  logic                              is_cf_i,
    input  logic                              ld_i,
    output logic [fetch_pkg::LADDR_W-1:0]     fetch_line_o
);

    logic [fetch_pkg::LADDR_W-1:0] cf_line;   // selected redirect
    logic [fetch_pkg::LADDR_W-1:0] line_q;    // fetch line register

    always_comb begin
        case (cf_sel_i)
            fetch_pkg::CF_SEL_INIT: cf_line = init_line_i;
            fetch_pkg::CF_SEL_WB:   cf_line = wb_line_i;
            fetch_pkg::CF_SEL_BP:   cf_line = bp_line_i;
            default:                cf_line = '0;
        endcase
    end

    // redirect shows up in the same cycle
    assign fetch_line_o = is_cf_i ? cf_line : line_q;

    // each bank steps over the other bank's line
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            line_q <= {{(fetch_pkg::LADDR_W-1){1'b0}}, PARITY};
        end else if (ld_i) begin
            line_q <= fetch_line_o + {{(fetch_pkg::LADDR_W-2){1'b0}}, 2'd2};
        end
    end

endmodule

/* src/fetch_ctrl.sv */
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              init_i,
    input  logic [fetch_pkg::VADDR_W-1:0]     init_addr_i,
    input  logic                              resteer_i,
    input  logic                              br_taken_i,
    input  logic                              even_taken_i,
    input  logic                              odd_taken_i,
    input  logic                              stall_e_i,
    input  logic                              stall_o_i,
    output logic [fetch_pkg::CF_SEL_W-1:0]    cf_sel_o,
    output logic                              is_cf_o,
    output logic                              ld_e_o,
    output logic                              ld_o_o,
    output logic [fetch_pkg::LADDR_W-1:0]     init_line_e_o,
    output logic [fetch_pkg::LADDR_W-1:0]     init_line_o_o
);

    fetch_pkg::fetch_addr_u             init_addr;
    logic [fetch_pkg::LADDR_W-1:0]      init_line;
    logic [fetch_pkg::LADDR_W-1:0]      init_line_p1;
    logic                               run_q;     // loads enabled

    //////////////////////////////////////////////////////////////////////
    // control-flow priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (init_i) begin
            cf_sel_o = fetch_pkg::CF_SEL_INIT;
        end else if (resteer_i) begin
            cf_sel_o = fetch_pkg::CF_SEL_WB;
        end else if (br_taken_i) begin
            cf_sel_o = fetch_pkg::CF_SEL_BP;
        end else begin
            cf_sel_o = '0;   // sequential
        end
    end

    assign is_cf_o = init_i | resteer_i | br_taken_i;

    //////////////////////////////////////////////////////////////////////
    // init split over the two banks
    //////////////////////////////////////////////////////////////////////

    assign init_addr    = init_addr_i;
    assign init_line    = {init_addr.line.upper, init_addr.line.index, init_addr.line.bank};
    assign init_line_p1 = init_line + 1'b1;

    // the bank that owns the init line takes it, the other one the next line
    assign init_line_e_o = init_addr.line.bank ? init_line_p1 : init_line;
    assign init_line_o_o = init_addr.line.bank ? init_line    : init_line_p1;

    //////////////////////////////////////////////////////////////////////
    // register load and clear
    //////////////////////////////////////////////////////////////////////

    // loads held off until reset release has been seen at an edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign ld_e_o = run_q & (is_cf_o | (even_taken_i & ~stall_e_i));
    assign ld_o_o = run_q & (is_cf_o | (odd_taken_i & ~stall_o_i));

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache bank geometry
    //////////////////////////////////////////////////////////////////////

    localparam int LINE_W     = 128;            // 16 bytes per line
    localparam int LINE_OFF_W = 4;              // byte offset within a line
    localparam int INDEX_W    = 4;
    localparam int NUM_SETS   = 1 << INDEX_W;   // 16 sets per bank

    // physical side
    localparam int PADDR_W = 15;
    localparam int PFN_W   = 3;
    localparam int TAG_W   = 6;                 // paddr[14:9], above index and bank

    //////////////////////////////////////////////////////////////////////
    // tlb geometry
    //////////////////////////////////////////////////////////////////////

    localparam int TLB_ENTRIES = 8;
    localparam int VPN_W       = 20;

endpackage

/* src/fetch_pkg.sv */
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // fetch address widths
    //////////////////////////////////////////////////////////////////////

    localparam int VADDR_W = 32;    // virtual fetch address
    localparam int LADDR_W = 28;    // 16-byte line address, vaddr[31:4]

    //////////////////////////////////////////////////////////////////////
    // control-flow select, one-hot
    //////////////////////////////////////////////////////////////////////

    localparam int CF_SEL_W = 3;

    localparam logic [CF_SEL_W-1:0] CF_SEL_BP   = 3'b001;  // predicted branch
    localparam logic [CF_SEL_W-1:0] CF_SEL_WB   = 3'b010;  // writeback resteer
    localparam logic [CF_SEL_W-1:0] CF_SEL_INIT = 3'b100;  // init

    // one virtual fetch address, split for the tlb (page) or the cache (line)
    typedef union packed {
        struct packed {
            logic [19:0] vpn;
            logic [11:0] offset;
        } page;
        struct packed {
            logic [VADDR_W-10:0] upper;     // tag side, bits 31:9
            logic [3:0]          index;     // set within a bank
            logic                bank;      // 0 even, 1 odd
            logic [3:0]          byte_off;
        } line;
    } fetch_addr_u;

endpackage
